// File: list.f
rtl/core_pkg.sv
rtl/lane_decode.sv
rtl/lane_alu.sv
rtl/reg_file.sv
rtl/scoreboard.sv
rtl/bundle_core.sv
verif/tb_bundle_core.sv

// File: verif/tb_bundle_core.sv
module tb_bundle_core;
  import core_pkg::*;

  localparam int NUM_LANES = 4;
  localparam int TIMEOUT   = 20;  // Cycles allowed per wait
  localparam int PKT_W     = NUM_LANES * XLEN;

  typedef wb_lane_t [NUM_LANES-1:0] wb_bundle_t;

  logic             clkrst_core_clk;
  logic             clkrst_core_rst_n;
  logic             packet_valid;
  logic [PKT_W-1:0] packet;
  logic             packet_ready;
  logic             wb_valid;
  wb_bundle_t       wb_lanes;

  logic [XLEN-1:0]  ref_regs [NUM_REGS];  // Reference register file
  wb_bundle_t       exp_q[$];
  int               acc_q[$];             // Acceptance edge of each expected bundle
  wb_bundle_t       obs_q[$];
  int               obs_cyc_q[$];
  int               cyc;
  int               sent_cnt;
  int               wb_cnt;
  int               check_cnt;
  int               mismatch_cnt;
  int               fail_cnt;

  bundle_core #(
    .NUM_LANES (NUM_LANES)
  ) i_dut (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .packet_valid      (packet_valid),
    .packet            (packet),
    .packet_ready      (packet_ready),
    .wb_valid          (wb_valid),
    .wb_lanes          (wb_lanes)
  );

  initial begin
    clkrst_core_clk = 1'b0;
    forever #50 clkrst_core_clk = ~clkrst_core_clk;
  end

  always @(posedge clkrst_core_clk) begin
    cyc <= cyc + 1;  // Counts rising edges
  end

  // Wb strobes are sampled mid-cycle, where outputs are settled
  always @(negedge clkrst_core_clk) begin
    if (clkrst_core_rst_n && wb_valid) begin
      obs_q.push_back(wb_lanes);
      obs_cyc_q.push_back(cyc);
      wb_cnt++;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      mismatch_cnt++;
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  function automatic logic [XLEN-1:0] r_inst(logic [3:0] op, logic [4:0] rd, logic [4:0] rs,
                                             logic [4:0] rt, logic [4:0] sh);
    return {op, rd, rs, rt, sh, 8'h00};
  endfunction

  function automatic logic [XLEN-1:0] i_inst(logic [3:0] op, logic [4:0] rd, logic [4:0] rs,
                                             logic [17:0] imm);
    return {op, rd, rs, imm};
  endfunction

  // All lanes read the registers as they were before the bundle
  function automatic wb_bundle_t model_bundle(logic [PKT_W-1:0] pkt);
    wb_bundle_t      exp;
    logic [XLEN-1:0] ins;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    for (int l = 0; l < NUM_LANES; l++) begin
      ins = pkt[l*XLEN +: XLEN];
      a   = ref_regs[ins[22:18]];
      b   = ref_regs[ins[17:13]];
      imm = {{14{ins[17]}}, ins[17:0]};
      case (ins[31:28])
        OP_ADD:  exp[l].data = a + b;
        OP_SUB:  exp[l].data = a - b;
        OP_AND:  exp[l].data = a & b;
        OP_OR:   exp[l].data = a | b;
        OP_XOR:  exp[l].data = a ^ b;
        OP_SLL:  exp[l].data = a << ins[12:8];
        OP_SRL:  exp[l].data = a >> ins[12:8];
        OP_ADDI: exp[l].data = a + imm;
        default: exp[l].data = '0;  // NOP and unknown opcodes
      endcase
      exp[l].rd      = ins[27:23];
      exp[l].invalid = (ins[31:28] > OP_ADDI);
      exp[l].we      = !exp[l].invalid && (ins[31:28] != OP_NOP) && (ins[27:23] != '0);
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int h = l + 1; h < NUM_LANES; h++) begin
        if (exp[h].we && (exp[h].rd == exp[l].rd)) begin
          exp[l].we = 1'b0;  // Higher lane wins
        end
      end
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      if (exp[l].we) begin
        ref_regs[exp[l].rd] = exp[l].data;
      end
    end
    return exp;
  endfunction

  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic send_bundle(input logic [PKT_W-1:0] pkt);
    int t;
    t            = 0;
    packet_valid = 1'b1;
    packet       = pkt;
    while (!packet_ready && t < TIMEOUT) begin
      @(negedge clkrst_core_clk);
      t++;
    end
    if (!packet_ready) begin
      fail_cnt++;
      $display("Timeout: packet not accepted within %0d cycles", TIMEOUT);
    end else begin
      acc_q.push_back(cyc + 1);  // Taken on the coming rising edge
      exp_q.push_back(model_bundle(pkt));
      sent_cnt++;
    end
    @(negedge clkrst_core_clk);
    packet_valid = 1'b0;
  endtask

  task automatic expect_wb(output int latency, output int wb_cyc);
    wb_bundle_t got;
    wb_bundle_t exp;
    int         t;
    t       = 0;
    latency = -1;
    wb_cyc  = -1;
    while (obs_q.size() == 0 && t < TIMEOUT) begin
      @(negedge clkrst_core_clk);
      t++;
    end
    if (obs_q.size() == 0) begin
      fail_cnt++;
      $display("Timeout: no writeback strobe within %0d cycles", TIMEOUT);
    end else if (exp_q.size() == 0) begin
      fail_cnt++;
      $display("Writeback strobe seen with no bundle outstanding");
    end else begin
      got     = obs_q.pop_front();
      exp     = exp_q.pop_front();
      wb_cyc  = obs_cyc_q.pop_front();
      latency = wb_cyc - acc_q.pop_front();
      for (int l = 0; l < NUM_LANES; l++) begin
        check_value($sformatf("wb_lanes[%0d].we", l), got[l].we, exp[l].we);
        check_value($sformatf("wb_lanes[%0d].rd", l), got[l].rd, exp[l].rd);
        check_value($sformatf("wb_lanes[%0d].data", l), got[l].data, exp[l].data);
        check_value($sformatf("wb_lanes[%0d].invalid", l), got[l].invalid, exp[l].invalid);
      end
    end
  endtask

  task automatic reset_state();
    check_value("packet_ready", packet_ready, 1);
    check_value("wb_valid", wb_valid, 0);
    for (int l = 0; l < NUM_LANES; l++) begin
      check_value($sformatf("wb_lanes[%0d].we", l), wb_lanes[l].we, 0);
    end
  endtask

  // Fills r1..r12 from r0, distinct targets keep every bundle independent
  task automatic immediate_loads();
    logic [PKT_W-1:0] pkt;
    int               lat;
    int               wc;
    for (int b = 0; b < 3; b++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        pkt[l*XLEN +: XLEN] = i_inst(OP_ADDI, 5'(1 + b * NUM_LANES + l), 5'd0, 18'($urandom));
      end
      send_bundle(pkt);
    end
    for (int b = 0; b < 3; b++) begin
      expect_wb(lat, wc);
      check_value("wb_valid latency", lat, 2);
    end
  endtask

  task automatic register_ops();
    logic [4:0] sh_a;
    logic [4:0] sh_b;
    int         lat;
    int         wc;
    sh_a = 5'($urandom);
    sh_b = 5'($urandom);
    send_bundle({r_inst(OP_OR, 16, 7, 8, 0), r_inst(OP_AND, 15, 5, 6, 0),
                 r_inst(OP_SUB, 14, 3, 4, 0), r_inst(OP_ADD, 13, 1, 2, 0)});
    send_bundle({r_inst(OP_SRL, 20, 12, 0, sh_b), r_inst(OP_SLL, 19, 11, 0, sh_a),
                 r_inst(OP_XOR, 18, 9, 10, 0), r_inst(OP_SUB, 17, 12, 1, 0)});
    expect_wb(lat, wc);
    expect_wb(lat, wc);
  endtask

  task automatic dependency_stall();
    int lat;
    int prod_cyc;
    int cons_cyc;
    send_bundle({96'h0, i_inst(OP_ADDI, 21, 1, 18'($urandom))});
    send_bundle({96'h0, r_inst(OP_ADD, 22, 21, 2, 0)});
    check_value("packet_ready", packet_ready, 0);  // Consumer held in decode
    expect_wb(lat, prod_cyc);
    expect_wb(lat, cons_cyc);
    check_value("wb_valid spacing", cons_cyc - prod_cyc, 3);
  endtask

  task automatic same_bundle_rules();
    int lat;
    int wc;
    // Lane 1 reads the old r1, lanes 2 and 3 both write r25
    send_bundle({i_inst(OP_ADDI, 25, 0, 18'd7), i_inst(OP_ADDI, 25, 0, 18'd5),
                 r_inst(OP_ADD, 24, 1, 0, 0), i_inst(OP_ADDI, 1, 0, 18'd100)});
    send_bundle({96'h0, r_inst(OP_ADD, 26, 25, 1, 0)});
    expect_wb(lat, wc);
    expect_wb(lat, wc);
  endtask

  task automatic invalid_and_zero();
    logic [PKT_W-1:0] pkt;
    int               lat;
    int               wc;
    send_bundle({32'h0, r_inst(OP_ADD, 27, 0, 1, 0), i_inst(OP_ADDI, 0, 0, 18'd55),
                 r_inst(4'hb, 9, 1, 2, 0)});
    send_bundle({96'h0, r_inst(OP_ADD, 28, 0, 0, 0)});
    expect_wb(lat, wc);
    expect_wb(lat, wc);
    for (int b = 0; b < 24; b++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        pkt[l*XLEN +: XLEN] = {4'($urandom_range(10, 0)), 28'($urandom)};
      end
      send_bundle(pkt);
    end
    for (int b = 0; b < 24; b++) begin
      expect_wb(lat, wc);
    end
    repeat (6) @(negedge clkrst_core_clk);  // Let any stray strobe show up
    check_value("wb strobe count", wb_cnt, sent_cnt);
  endtask

  initial begin
    void'($urandom(32'h7433540e));
    cyc               = 0;
    sent_cnt          = 0;
    wb_cnt            = 0;
    check_cnt         = 0;
    mismatch_cnt      = 0;
    fail_cnt          = 0;
    packet_valid      = 1'b0;
    packet            = '0;
    clkrst_core_rst_n = 1'b0;
    for (int r = 0; r < NUM_REGS; r++) begin
      ref_regs[r] = '0;
    end
    repeat (2) @(negedge clkrst_core_clk);
    clkrst_core_rst_n = 1'b1;
    reset_state();
    immediate_loads();
    register_ops();
    dependency_stall();
    same_bundle_rules();
    invalid_and_zero();
    $display("Checks %0d, mismatches %0d, other failures %0d",
             check_cnt, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: rtl/bundle_core.sv
module bundle_core #(
  parameter int NUM_LANES = 4
) (
  input  logic                                    clkrst_core_clk,
  input  logic                                    clkrst_core_rst_n,
  input  logic                                    packet_valid,
  input  logic [NUM_LANES*core_pkg::XLEN-1:0]     packet,
  output logic                                    packet_ready,
  output logic                                    wb_valid,
  output core_pkg::wb_lane_t [NUM_LANES-1:0]      wb_lanes
);
  import core_pkg::*;

  inst_u    [NUM_LANES-1:0] dcd_inst;  // Lane 0 in the low word
  logic                     dcd_valid;
  logic                     ex_valid;
  logic                     packet_take;
  logic                     dcd_issue;
  logic                     dcd_stall;

  lane_op_t [NUM_LANES-1:0] dcd_ops;
  lane_op_t [NUM_LANES-1:0] ex_ops;
  wb_lane_t [NUM_LANES-1:0] wb_next;
  wb_lane_t [NUM_LANES-1:0] wb_q;

  logic [NUM_LANES-1:0][REG_NUM_W-1:0] rs_num;
  logic [NUM_LANES-1:0][REG_NUM_W-1:0] rt_num;
  logic [NUM_LANES-1:0]                reads_rt;
  logic [NUM_LANES-1:0][XLEN-1:0]      rs_data;
  logic [NUM_LANES-1:0][XLEN-1:0]      rt_data;
  logic [NUM_LANES-1:0][XLEN-1:0]      ex_result;

  // Execute and writeback never back-pressure, so only decode can hold
  assign dcd_issue    = dcd_valid && !dcd_stall;
  assign packet_ready = !dcd_valid || dcd_issue;
  assign packet_take  = packet_valid && packet_ready;

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      dcd_valid <= 1'b0;
      ex_valid  <= 1'b0;
      wb_valid  <= 1'b0;
    end else begin
      if (packet_ready) begin
        dcd_valid <= packet_valid;
      end
      ex_valid <= dcd_issue;
      wb_valid <= ex_valid;
    end
  end

  // Stage payloads, each loaded on its own progress
  always_ff @(posedge clkrst_core_clk) begin
    if (packet_take) begin
      dcd_inst <= packet;
    end
    if (dcd_issue) begin
      ex_ops <= dcd_ops;
    end
    if (ex_valid) begin
      wb_q <= wb_next;
    end
  end

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    lane_decode i_decode (
      .inst     (dcd_inst[l]),
      .rs_data  (rs_data[l]),
      .rt_data  (rt_data[l]),
      .rs_num   (rs_num[l]),
      .rt_num   (rt_num[l]),
      .reads_rt (reads_rt[l]),
      .lane_op  (dcd_ops[l])
    );

    lane_alu i_alu (
      .lane_op (ex_ops[l]),
      .result  (ex_result[l])
    );
  end

  // Higher lane wins a shared rd, lower lanes lose their write
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      wb_next[l].we      = ex_ops[l].rd_we;
      wb_next[l].rd      = ex_ops[l].rd;
      wb_next[l].data    = ex_result[l];
      wb_next[l].invalid = ex_ops[l].invalid;
      for (int h = l + 1; h < NUM_LANES; h++) begin
        if (ex_ops[h].rd_we && (ex_ops[h].rd == ex_ops[l].rd)) begin
          wb_next[l].we = 1'b0;
        end
      end
    end
  end

  // Writes only count during the strobe cycle
  always_comb begin
    wb_lanes = wb_q;
    for (int l = 0; l < NUM_LANES; l++) begin
      wb_lanes[l].we = wb_q[l].we && wb_valid;
    end
  end

  reg_file #(
    .NUM_LANES (NUM_LANES)
  ) i_reg_file (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .rs_num            (rs_num),
    .rt_num            (rt_num),
    .rs_data           (rs_data),
    .rt_data           (rt_data),
    .wb_lanes          (wb_lanes)
  );

  scoreboard #(
    .NUM_LANES (NUM_LANES)
  ) i_scoreboard (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .dcd_valid         (dcd_valid),
    .issue             (dcd_issue),
    .lane_ops          (dcd_ops),
    .rs_num            (rs_num),
    .rt_num            (rt_num),
    .reads_rt          (reads_rt),
    .wb_lanes          (wb_lanes),
    .stall             (dcd_stall)
  );

  a_dcd_hold: assert property (
    @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
    (dcd_valid && dcd_stall) |=> (dcd_valid && $stable(dcd_inst))
  );

endmodule

// File: rtl/scoreboard.sv
module scoreboard #(
  parameter int NUM_LANES = 4
) (
  input  logic                                            clkrst_core_clk,
  input  logic                                            clkrst_core_rst_n,
  input  logic                                            dcd_valid,
  input  logic                                            issue,
  input  core_pkg::lane_op_t [NUM_LANES-1:0]              lane_ops,
  input  logic [NUM_LANES-1:0][core_pkg::REG_NUM_W-1:0]   rs_num,
  input  logic [NUM_LANES-1:0][core_pkg::REG_NUM_W-1:0]   rt_num,
  input  logic [NUM_LANES-1:0]                            reads_rt,
  input  core_pkg::wb_lane_t [NUM_LANES-1:0]              wb_lanes,
  output logic                                            stall
);
  import core_pkg::*;

  logic [NUM_REGS-1:0] pending;  // One bit per register with a write in flight
  logic [NUM_REGS-1:0] set_mask;
  logic [NUM_REGS-1:0] clr_mask;
  logic                hazard;

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    hazard   = 1'b0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (lane_ops[l].rd_we) begin
        set_mask[lane_ops[l].rd] = 1'b1;
      end
      if (wb_lanes[l].we) begin
        clr_mask[wb_lanes[l].rd] = 1'b1;
      end
      if (pending[rs_num[l]]) begin
        hazard = 1'b1; // RAW on rs
      end
      if (reads_rt[l] && pending[rt_num[l]]) begin
        hazard = 1'b1; // RAW on rt
      end
    end
    if ((set_mask & pending) != '0) begin
      hazard = 1'b1; // WAW against an older bundle
    end
  end

  assign stall = dcd_valid && hazard;

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      pending <= '0;
    end else if (issue) begin
      pending <= (pending & ~clr_mask) | set_mask;
    end else begin
      pending <= pending & ~clr_mask;
    end
  end

  // Top level only issues when stall is low
  a_no_double_set: assert property (
    @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
    issue |-> ((set_mask & pending) == '0)
  );

endmodule

// File: rtl/reg_file.sv
module reg_file #(
  parameter int NUM_LANES = 4
) (
  input  logic                                            clkrst_core_clk,
  input  logic                                            clkrst_core_rst_n,
  input  logic [NUM_LANES-1:0][core_pkg::REG_NUM_W-1:0]   rs_num,
  input  logic [NUM_LANES-1:0][core_pkg::REG_NUM_W-1:0]   rt_num,
  output logic [NUM_LANES-1:0][core_pkg::XLEN-1:0]        rs_data,
  output logic [NUM_LANES-1:0][core_pkg::XLEN-1:0]        rt_data,
  input  core_pkg::wb_lane_t [NUM_LANES-1:0]              wb_lanes
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  // Lanes are applied in order so the highest lane wins a shared rd
  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (wb_lanes[l].we && (wb_lanes[l].rd != '0)) begin
          regs[wb_lanes[l].rd] <= wb_lanes[l].data;
        end
      end
    end
  end

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      rs_data[l] = (rs_num[l] == '0) ? '0 : regs[rs_num[l]]; // r0 is hardwired zero
      rt_data[l] = (rt_num[l] == '0) ? '0 : regs[rt_num[l]];
    end
  end

  // Decode already drops r0 destinations before they reach writeback
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_chk
    a_no_r0_write: assert property (
      @(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
      wb_lanes[l].we |-> (wb_lanes[l].rd != '0)
    );
  end

endmodule

// File: rtl/lane_alu.sv
module lane_alu (
  input  core_pkg::lane_op_t          lane_op,
  output logic [core_pkg::XLEN-1:0]   result
);
  import core_pkg::*;

  logic [XLEN-1:0]    op_a;
  logic [XLEN-1:0]    op_b;
  logic [SHAMT_W-1:0] shamt;

  assign op_a  = lane_op.operand_a;
  assign op_b  = lane_op.operand_b;
  assign shamt = op_b[SHAMT_W-1:0]; // Decode puts shamt in the low bits

  always_comb begin
    case (lane_op.op)
      OP_ADD, OP_ADDI: begin
        result = op_a + op_b;
      end
      OP_SUB: begin
        result = op_a - op_b;
      end
      OP_AND: begin
        result = op_a & op_b;
      end
      OP_OR: begin
        result = op_a | op_b;
      end
      OP_XOR: begin
        result = op_a ^ op_b;
      end
      OP_SLL: begin
        result = op_a << shamt;
      end
      OP_SRL: begin
        result = op_a >> shamt; // Logical
      end
      default: begin
        result = '0; // NOP and unknown opcodes
      end
    endcase
  end

endmodule

// File: rtl/lane_decode.sv
module lane_decode (
  input  core_pkg::inst_u                  inst,
  input  logic [core_pkg::XLEN-1:0]        rs_data,
  input  logic [core_pkg::XLEN-1:0]        rt_data,
  output logic [core_pkg::REG_NUM_W-1:0]   rs_num,
  output logic [core_pkg::REG_NUM_W-1:0]   rt_num,
  output logic                             reads_rt,
  output core_pkg::lane_op_t               lane_op
);
  import core_pkg::*;

  logic            op_known;
  logic            op_nop;
  logic            uses_rt;
  logic            uses_shamt;
  logic            uses_imm;
  logic [XLEN-1:0] imm_sext;
  logic [XLEN-1:0] shamt_ext;

  always_comb begin
    op_known   = 1'b1;
    op_nop     = 1'b0;
    uses_rt    = 1'b0;
    uses_shamt = 1'b0;
    uses_imm   = 1'b0;
    case (inst.r.opcode)
      OP_NOP: begin
        op_nop = 1'b1;
      end
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        uses_rt = 1'b1;
      end
      OP_SLL, OP_SRL: begin
        uses_shamt = 1'b1;
      end
      OP_ADDI: begin
        uses_imm = 1'b1;
      end
      default: begin
        op_known = 1'b0;
      end
    endcase
  end

  assign imm_sext  = {{(XLEN-IMM_W){inst.i.imm[IMM_W-1]}}, inst.i.imm};
  assign shamt_ext = {{(XLEN-SHAMT_W){1'b0}}, inst.r.shamt};

  // A lane with no real source points at r0, which is never pending
  assign rs_num   = (op_known && !op_nop) ? inst.r.rs : '0;
  assign rt_num   = uses_rt ? inst.r.rt : '0;
  assign reads_rt = uses_rt;

  always_comb begin
    lane_op.rd_we     = op_known && !op_nop && (inst.r.rd != '0); // r0 writes dropped here
    lane_op.rd        = inst.r.rd;
    lane_op.op        = inst.r.opcode;
    lane_op.operand_a = rs_data;
    lane_op.invalid   = !op_known;
    if (uses_rt) begin
      lane_op.operand_b = rt_data;
    end else if (uses_shamt) begin
      lane_op.operand_b = shamt_ext;
    end else if (uses_imm) begin
      lane_op.operand_b = imm_sext;
    end else begin
      lane_op.operand_b = '0;
    end
  end

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

  localparam int XLEN      = 32;
  localparam int REG_NUM_W = 5;
  localparam int NUM_REGS  = 32;
  localparam int OPC_W     = 4;
  localparam int SHAMT_W   = 5;
  localparam int IMM_W     = 18;
  localparam int SPARE_W   = XLEN - OPC_W - 3 * REG_NUM_W - SHAMT_W;

  localparam logic [OPC_W-1:0] OP_NOP  = 4'd0;
  localparam logic [OPC_W-1:0] OP_ADD  = 4'd1;
  localparam logic [OPC_W-1:0] OP_SUB  = 4'd2;
  localparam logic [OPC_W-1:0] OP_AND  = 4'd3;
  localparam logic [OPC_W-1:0] OP_OR   = 4'd4;
  localparam logic [OPC_W-1:0] OP_XOR  = 4'd5;
  localparam logic [OPC_W-1:0] OP_SLL  = 4'd6; // rs << shamt
  localparam logic [OPC_W-1:0] OP_SRL  = 4'd7; // rs >> shamt, zero fill
  localparam logic [OPC_W-1:0] OP_ADDI = 4'd8; // rs + sign-extended imm

  // Register form, bits 31:0
  typedef struct packed {
    logic [OPC_W-1:0]     opcode;  // 31:28
    logic [REG_NUM_W-1:0] rd;      // 27:23
    logic [REG_NUM_W-1:0] rs;      // 22:18
    logic [REG_NUM_W-1:0] rt;      // 17:13
    logic [SHAMT_W-1:0]   shamt;   // 12:8
    logic [SPARE_W-1:0]   spare;   // 7:0, ignored
  } inst_r_t;

  // Immediate form shares opcode, rd and rs with the register form
  typedef struct packed {
    logic [OPC_W-1:0]     opcode;
    logic [REG_NUM_W-1:0] rd;
    logic [REG_NUM_W-1:0] rs;
    logic [IMM_W-1:0]     imm;     // Signed
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

  // Execute stage payload for one lane
  typedef struct packed {
    logic                 rd_we;
    logic [REG_NUM_W-1:0] rd;
    logic [OPC_W-1:0]     op;
    logic [XLEN-1:0]      operand_a;
    logic [XLEN-1:0]      operand_b;
    logic                 invalid;
  } lane_op_t;

  // Writeback payload for one lane
  typedef struct packed {
    logic                 we;
    logic [REG_NUM_W-1:0] rd;
    logic [XLEN-1:0]      data;
    logic                 invalid;
  } wb_lane_t;

endpackage
